// ==== Bender.yml ====
package:
  name: mips_cpu_bus

sources:
  - include_dirs:
      - src
    files:
      - src/mips_pkg.sv
      - src/mips_intf.sv
      - src/reg_file.sv
      - src/instr_exec.sv
      - src/cpu_control.sv
      - src/mips_cpu_bus.sv
  - target: test
    include_dirs:
      - src
    files:
      - verif/mips_bus_assert.sv
      - verif/tb_mips_cpu_bus.sv

// ==== compile.f ====
+incdir+src
src/mips_pkg.sv
src/mips_intf.sv
src/reg_file.sv
src/instr_exec.sv
src/cpu_control.sv
src/mips_cpu_bus.sv
verif/mips_bus_assert.sv
verif/tb_mips_cpu_bus.sv

// ==== src/cpu_control.sv ====
// MIPS core controller: fetch/execute/write-back FSM, pc, delay-slot jumps and Avalon requests
`timescale 1ns/1ps
`include "mips_cfg.svh"

module cpu_control import mips_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    waitrequest,
    input  logic [`MIPS_XLEN-1:0]   readdata,
    output logic                    active,
    output logic [`MIPS_XLEN-1:0]   address,
    output logic                    read,
    output logic                    write,
    output logic [`MIPS_XLEN-1:0]   writedata,
    output logic [`MIPS_XLEN/8-1:0] byteenable,
    exec_if.ctrl                    ex
);

    cpu_state_t            state;
    logic [`MIPS_XLEN-1:0] pc;
    logic [`MIPS_XLEN-1:0] jump_pc;                       // target waiting for its delay slot
    logic                  jump_pending;
    decoded_t              ir;
    logic                  ir_valid;                      // ir holds the current instruction
    logic                  mem_op;
    logic                  mem_stall;

    assign mem_op    = ex.is_load | ex.is_store;
    assign mem_stall = mem_op & waitrequest;              // the data access is not yet accepted

    // the fetched word is on readdata only in the first EXEC cycle
    assign ex.instr    = ir_valid ? ir : decoded_t'(readdata);
    assign ex.pc       = pc;
    assign ex.commit   = (state == EXEC) && !mem_stall;
    assign ex.load_ret = (state == WRITE_BACK);
    assign ex.rdata    = readdata;

    assign writedata = ex.store_data;

    always_comb begin
        read       = 1'b0;
        write      = 1'b0;
        address    = pc;
        byteenable = '1;
        case (state)
            FETCH: begin
                read = 1'b1;
            end
            EXEC: begin
                address    = ex.mem_addr;
                read       = ex.is_load;
                write      = ex.is_store;
                byteenable = ex.misalign ? '0 : '1;       // a misaligned word access touches no lane
            end
            default: begin
                read  = 1'b0;
                write = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= FETCH;
            active       <= 1'b1;
            pc           <= `MIPS_RESET_VECTOR;
            jump_pending <= 1'b0;
            ir_valid     <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    ir_valid <= 1'b0;
                    if (pc == `MIPS_HALT_ADDR) begin
                        state  <= HALTED;
                        active <= 1'b0;
                    end else if (!waitrequest) begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    ir_valid <= 1'b1;
                    if (!mem_stall) begin
                        // the instruction after a taken jump runs first, then the target
                        pc           <= jump_pending ? jump_pc : pc + 4;
                        jump_pending <= ex.take_jump;
                        state        <= ex.is_load ? WRITE_BACK : FETCH;
                    end
                end
                WRITE_BACK: begin
                    state <= FETCH;
                end
                default: begin
                    state <= HALTED;                      // stays here until the next reset
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == EXEC && !ir_valid) begin
            ir <= decoded_t'(readdata);
        end
        if (ex.commit && ex.take_jump) begin
            jump_pc <= ex.jump_target;
        end
    end

endmodule

// ==== src/instr_exec.sv ====
// MIPS execute unit that decodes, runs the ALU, resolves branches and jumps and drives register writes
`timescale 1ns/1ps
`include "mips_cfg.svh"

module instr_exec import mips_pkg::*; (
    input  logic clk,
    input  logic reset,
    exec_if.exec ex,
    reg_if.exec  rf
);

    decoded_t              instr;
    logic [4:0]            rs;
    logic [4:0]            rt;
    logic [4:0]            rd;
    logic [4:0]            shamt;
    funct_t                funct;
    logic [15:0]           imm;
    logic [`MIPS_XLEN-1:0] a;                             // value of rs
    logic [`MIPS_XLEN-1:0] b;                             // value of rt
    logic [`MIPS_XLEN-1:0] sext_imm;
    logic [`MIPS_XLEN-1:0] zext_imm;
    logic [`MIPS_XLEN-1:0] pc_plus4;
    logic [`MIPS_XLEN-1:0] eff_addr;
    logic [`MIPS_XLEN-1:0] alu_y;
    logic                  alu_wr;
    logic [4:0]            alu_wa;
    logic                  load_pending;
    logic [4:0]            load_rt;

    assign instr = ex.instr;
    assign rs    = instr.body.f.rs;
    assign rt    = instr.body.f.rt;
    assign rd    = instr.body.f.low.r.rd;
    assign shamt = instr.body.f.low.r.shamt;
    assign funct = instr.body.f.low.r.funct;
    assign imm   = instr.body.f.low.imm;

    assign rf.raddr_a = rs;
    assign rf.raddr_b = rt;
    assign a          = rf.rdata_a;
    assign b          = rf.rdata_b;

    assign sext_imm = {{16{imm[15]}}, imm};
    assign zext_imm = {16'h0000, imm};
    assign pc_plus4 = ex.pc + 4;

    // loads and stores always use base plus offset
    assign eff_addr      = a + sext_imm;
    assign ex.mem_addr   = {eff_addr[`MIPS_XLEN-1:2], 2'b00};
    assign ex.misalign   = |eff_addr[1:0];
    assign ex.store_data = b;

    always_comb begin
        alu_y          = '0;
        alu_wr         = 1'b0;
        alu_wa         = rt;
        ex.is_load     = 1'b0;
        ex.is_store    = 1'b0;
        ex.take_jump   = 1'b0;
        ex.jump_target = pc_plus4 + {sext_imm[`MIPS_XLEN-3:0], 2'b00};   // branch target
        case (instr.opcode)
            OP_RTYPE: begin
                alu_wa = rd;
                alu_wr = 1'b1;
                case (funct)
                    FN_ADDU: alu_y = a + b;
                    FN_SUBU: alu_y = a - b;
                    FN_AND:  alu_y = a & b;
                    FN_OR:   alu_y = a | b;
                    FN_XOR:  alu_y = a ^ b;
                    FN_SLT:  alu_y = {31'b0, $signed(a) < $signed(b)};
                    FN_SLTU: alu_y = {31'b0, a < b};
                    FN_SLL:  alu_y = b << shamt;
                    FN_SRL:  alu_y = b >> shamt;
                    FN_SRA:  alu_y = $signed(b) >>> shamt;
                    FN_SLLV: alu_y = b << a[4:0];
                    FN_SRLV: alu_y = b >> a[4:0];
                    FN_SRAV: alu_y = $signed(b) >>> a[4:0];
                    FN_JR: begin
                        alu_wr         = 1'b0;
                        ex.take_jump   = 1'b1;
                        ex.jump_target = a;
                    end
                    default: alu_wr = 1'b0;               // unknown functions change nothing
                endcase
            end
            OP_ADDIU: begin
                alu_y  = a + sext_imm;
                alu_wr = 1'b1;
            end
            OP_SLTI: begin
                alu_y  = {31'b0, $signed(a) < $signed(sext_imm)};
                alu_wr = 1'b1;
            end
            OP_SLTIU: begin
                alu_y  = {31'b0, a < sext_imm};
                alu_wr = 1'b1;
            end
            OP_ANDI: begin
                alu_y  = a & zext_imm;
                alu_wr = 1'b1;
            end
            OP_ORI: begin
                alu_y  = a | zext_imm;
                alu_wr = 1'b1;
            end
            OP_XORI: begin
                alu_y  = a ^ zext_imm;
                alu_wr = 1'b1;
            end
            OP_LUI: begin
                alu_y  = {imm, 16'h0000};
                alu_wr = 1'b1;
            end
            OP_BEQ:   ex.take_jump = (a == b);
            OP_BNE:   ex.take_jump = (a != b);
            OP_J: begin
                ex.take_jump   = 1'b1;
                ex.jump_target = {pc_plus4[`MIPS_XLEN-1:28], instr.body.index, 2'b00};
            end
            OP_LW:    ex.is_load = 1'b1;
            OP_SW:    ex.is_store = 1'b1;
            default:  alu_wr = 1'b0;
        endcase
    end

    // commit and load return never fall in the same cycle
    assign rf.wen   = (ex.commit && alu_wr) || (ex.load_ret && load_pending);
    assign rf.waddr = ex.load_ret ? load_rt : alu_wa;
    assign rf.wdata = ex.load_ret ? ex.rdata : alu_y;

    always_ff @(posedge clk) begin
        if (reset) begin
            load_pending <= 1'b0;
        end else if (ex.commit && ex.is_load) begin
            load_pending <= 1'b1;
        end else if (ex.load_ret) begin
            load_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ex.commit && ex.is_load) begin
            load_rt <= rt;                                // destination of the returning word
        end
    end

endmodule

// ==== src/mips_cfg.svh ====
// MIPS core configuration: boot and halt addresses, data width and register file sizing
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// first instruction fetched after reset
`define MIPS_RESET_VECTOR 32'hBFC0_0000

// a fetch from this address stops the core
`define MIPS_HALT_ADDR 32'h0000_0000

// width of the data path, the address bus and every general register
`define MIPS_XLEN 32

// number of general registers, index zero always reads as zero
`define MIPS_NUM_REGS 32

// index of $v0, exported at the top level
`define MIPS_REG_V0 2

`endif

// ==== src/mips_cpu_bus.sv ====
// MIPS32 multi-cycle core with an Avalon memory-mapped master port
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_cpu_bus (
    input  logic                      clk,
    input  logic                      reset,
    output logic                      active,
    output logic [`MIPS_XLEN-1:0]     register_v0,

    // Avalon master
    output logic [`MIPS_XLEN-1:0]     address,
    output logic                      write,
    output logic                      read,
    input  logic                      waitrequest,
    output logic [`MIPS_XLEN-1:0]     writedata,
    output logic [`MIPS_XLEN/8-1:0]   byteenable,
    input  logic [`MIPS_XLEN-1:0]     readdata
);

    reg_if  rf_bus ();
    exec_if ex_bus ();

    // sequencing and all bus traffic
    cpu_control u_control (
        .clk         (clk),
        .reset       (reset),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .active      (active),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .ex          (ex_bus.ctrl)
    );

    // decode, ALU and branch resolution
    instr_exec u_exec (
        .clk   (clk),
        .reset (reset),
        .ex    (ex_bus.exec),
        .rf    (rf_bus.exec)
    );

    reg_file u_regs (
        .clk         (clk),
        .reset       (reset),
        .rf          (rf_bus.rf),
        .register_v0 (register_v0)
    );

endmodule

// ==== src/mips_intf.sv ====
// MIPS core internal interfaces: register file ports and the controller to execute unit link
`timescale 1ns/1ps
`include "mips_cfg.svh"

interface reg_if;
    localparam int AW = $clog2(`MIPS_NUM_REGS);

    logic [AW-1:0]         raddr_a;
    logic [AW-1:0]         raddr_b;
    logic [`MIPS_XLEN-1:0] rdata_a;                       // combinational read of raddr_a
    logic [`MIPS_XLEN-1:0] rdata_b;
    logic                  wen;                           // write lands at the next clock edge
    logic [AW-1:0]         waddr;
    logic [`MIPS_XLEN-1:0] wdata;

    modport exec (output raddr_a, raddr_b, wen, waddr, wdata, input rdata_a, rdata_b);
    modport rf (input raddr_a, raddr_b, wen, waddr, wdata, output rdata_a, rdata_b);
endinterface

interface exec_if import mips_pkg::*; ();
    decoded_t              instr;                         // instruction in EXEC or WRITE_BACK
    logic [`MIPS_XLEN-1:0] pc;                            // address of that instruction
    logic                  commit;                        // EXEC step finishes this cycle
    logic                  load_ret;                      // WRITE_BACK cycle of a load
    logic [`MIPS_XLEN-1:0] rdata;
    logic                  is_load;
    logic                  is_store;
    logic [`MIPS_XLEN-1:0] mem_addr;                      // word aligned
    logic                  misalign;
    logic [`MIPS_XLEN-1:0] store_data;
    logic                  take_jump;
    logic [`MIPS_XLEN-1:0] jump_target;

    modport ctrl (
        output instr, pc, commit, load_ret, rdata,
        input  is_load, is_store, mem_addr, misalign, store_data, take_jump, jump_target
    );
    modport exec (
        input  instr, pc, commit, load_ret, rdata,
        output is_load, is_store, mem_addr, misalign, store_data, take_jump, jump_target
    );
endinterface

// ==== src/mips_pkg.sv ====
// MIPS core types: opcode and function encodings, FSM states and the instruction word layout
package mips_pkg;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,                             // decoded further by funct
        OP_J     = 6'b000010,
        OP_BEQ   = 6'b000100,
        OP_BNE   = 6'b000101,
        OP_ADDIU = 6'b001001,
        OP_SLTI  = 6'b001010,
        OP_SLTIU = 6'b001011,
        OP_ANDI  = 6'b001100,
        OP_ORI   = 6'b001101,
        OP_XORI  = 6'b001110,
        OP_LUI   = 6'b001111,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opcode_t;

    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_JR   = 6'b001000,
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_t;

    typedef enum logic [1:0] {
        FETCH      = 2'b00,
        EXEC       = 2'b01,
        WRITE_BACK = 2'b10,
        HALTED     = 2'b11
    } cpu_state_t;

    // the low 16 bits hold either rd/shamt/funct or the immediate
    typedef struct packed {
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_t     funct;
    } r_fields_t;

    typedef union packed {
        r_fields_t   r;
        logic [15:0] imm;
    } low_half_t;

    typedef struct packed {
        logic [4:0] rs;
        logic [4:0] rt;
        low_half_t  low;
    } reg_fields_t;

    // J-type reuses the same 26 bits as a jump index
    typedef union packed {
        reg_fields_t f;
        logic [25:0] index;
    } body_t;

    typedef struct packed {
        opcode_t opcode;
        body_t   body;
    } decoded_t;

endpackage

// ==== src/reg_file.sv ====
// MIPS general register file: two combinational reads, one write, register zero fixed at zero
`timescale 1ns/1ps
`include "mips_cfg.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  reset,
    reg_if.rf                     rf,
    output logic [`MIPS_XLEN-1:0] register_v0
);

    logic [`MIPS_XLEN-1:0] regs [`MIPS_NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.wen && rf.waddr != '0) begin
            regs[rf.waddr] <= rf.wdata;                   // writes to $zero are dropped here
        end
    end

    // $zero reads as zero even before the first reset
    assign rf.rdata_a = (rf.raddr_a == '0) ? '0 : regs[rf.raddr_a];
    assign rf.rdata_b = (rf.raddr_b == '0) ? '0 : regs[rf.raddr_b];

    assign register_v0 = regs[`MIPS_REG_V0];

endmodule

// ==== verif/mips_bus_assert.sv ====
// Avalon master protocol and halt checks bound into the MIPS core controller
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_bus_assert (
    input logic        clk,
    input logic        reset,
    input logic        read,
    input logic        write,
    input logic        waitrequest,
    input logic        active,
    input logic [31:0] address,
    input logic [31:0] writedata
);

    a_no_overlap: assert property (@(posedge clk) disable iff (reset) !(read && write))
        else $error("read and write are high together");

    // a fetch from the halt address is dropped by the halt itself
    a_read_held: assert property (@(posedge clk) disable iff (reset)
        read && waitrequest && address != `MIPS_HALT_ADDR |=> read && $stable(address))
        else $error("a stalled read changed before it was accepted");

    a_write_held: assert property (@(posedge clk) disable iff (reset)
        write && waitrequest |=> write && $stable(address) && $stable(writedata))
        else $error("a stalled write changed before it was accepted");

    a_halted_quiet: assert property (@(posedge clk) disable iff (reset)
        !active |-> !read && !write)
        else $error("bus request while the core is halted");

endmodule

bind cpu_control mips_bus_assert u_bus_assert (.*);

// ==== verif/tb_mips_cpu_bus.sv ====
// testbench for the MIPS Avalon core with a random program, a memory model and an instruction model
`timescale 1ns/1ps
`include "mips_cfg.svh"

module tb_mips_cpu_bus import mips_pkg::*; ();
    localparam logic [31:0] RV = `MIPS_RESET_VECTOR;
    localparam int NUM_INSTR = 40;
    localparam int DATA_BASE = 'h1000;
    localparam int DATA_WORDS = 64;
    localparam int TIMEOUT_NS = 2 * NUM_INSTR * 16 * 100 + 10000;   // two runs plus margin

    logic        clk = 1'b0;
    logic        reset;
    logic        waitrequest;
    logic        active;
    logic        read;
    logic        write;
    logic [31:0] readdata;
    logic [31:0] register_v0;
    logic [31:0] address;
    logic [31:0] writedata;
    logic [3:0]  byteenable;

    logic [31:0] init_mem [logic [31:0]];
    logic [31:0] bus_mem [logic [31:0]];
    logic [31:0] model_mem [logic [31:0]];
    logic [31:0] model_regs [32];
    bit          exp_write [$];                           // expected bus accesses in order
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [3:0]  exp_be [$];
    int          txn_idx = 0;
    int          wait_run = 0;
    bit          halt_seen = 0;

    mips_cpu_bus dut0 (
        .clk(clk), .reset(reset), .active(active), .register_v0(register_v0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    always #50 clk = ~clk;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string test, input logic [31:0] exp, act);
        stop_run($sformatf("mismatch %s: expected %h, actual %h", test, exp, act));
    endtask

    function automatic logic [31:0] enc_r(input logic [4:0] rs, rt, rd, sh, input logic [5:0] fn);
        return {6'b000000, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs, rt,
                                          input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic add_txn(input bit wr, input logic [31:0] a, d, input logic [3:0] be);
        exp_write.push_back(wr);
        exp_addr.push_back(a);
        exp_data.push_back(d);
        exp_be.push_back(be);
    endtask

    task automatic build_program();
        logic [5:0]  rfn [13] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLTU,
                                  FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};
        logic [5:0]  iop [7] = '{OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
        logic [31:0] w;
        logic [31:0] t;
        logic [15:0] off16;
        int          kind;
        int          off;
        int          n_store;
        bit          prev_ctrl;
        prev_ctrl = 0;
        n_store = 0;
        for (int k = 0; k < DATA_WORDS; k++) init_mem[DATA_BASE + 4 * k] = $urandom;
        for (int i = 0; i < NUM_INSTR - 2; i++) begin
            kind = $urandom_range(19, 0);
            if (kind >= 16 && (prev_ctrl || i > NUM_INSTR - 4)) kind = 0;   // keep delay slots plain
            off = $urandom_range(3, 1);
            if (i + 1 + off > NUM_INSTR - 2) off = NUM_INSTR - 3 - i;
            off16 = DATA_BASE + 4 * $urandom_range(DATA_WORDS - 1, 0);
            if (kind < 7) begin
                w = enc_r($urandom_range(7, 1), $urandom_range(7, 0), $urandom_range(7, 0),
                          $urandom_range(31, 0), rfn[$urandom_range(12, 0)]);
            end else if (kind < 12) begin
                w = enc_i(iop[$urandom_range(6, 0)], $urandom_range(7, 1), $urandom_range(7, 0),
                          $urandom);
            end else if (kind < 14) begin
                w = enc_i(OP_LW, 0, $urandom_range(7, 0), off16);
            end else if (kind < 16) begin
                if (n_store % 3 == 0) off16 = off16 + $urandom_range(3, 1);   // every third store
                n_store++;
                w = enc_i(OP_SW, 0, $urandom_range(7, 1), off16);
            end else if (kind < 19) begin
                w = enc_i(kind < 18 ? OP_BEQ : OP_BNE, $urandom_range(7, 1), $urandom_range(7, 0),
                          off);
            end else begin
                t = RV + 4 * (i + 1 + off);
                w = {OP_J, t[27:2]};
            end
            prev_ctrl = (kind >= 16);
            init_mem[RV + 4 * i] = w;
        end
        init_mem[RV + 4 * (NUM_INSTR - 2)] = enc_r(0, 0, 0, 0, FN_JR);
        init_mem[RV + 4 * (NUM_INSTR - 1)] = 32'h0000_0000;
    endtask

    // sequential execution with one delay slot after every taken branch or jump
    task automatic run_model();
        logic [31:0] pc, npc, tgt, ntgt, w, a, b, se, ze, val, ea;
        logic [4:0]  wa;
        bit          pend, take, wr;
        model_mem = init_mem;
        foreach (model_regs[i]) model_regs[i] = '0;
        pc = RV;
        pend = 0;
        tgt = '0;
        while (pc != `MIPS_HALT_ADDR) begin
            w = init_mem.exists(pc) ? init_mem[pc] : '0;
            add_txn(0, pc, '0, 4'hf);
            a = model_regs[w[25:21]];
            b = model_regs[w[20:16]];
            se = {{16{w[15]}}, w[15:0]};
            ze = {16'h0000, w[15:0]};
            ea = a + se;
            take = 0;
            wr = 1;
            wa = w[20:16];
            val = '0;
            ntgt = pc + 4 + (se << 2);
            case (w[31:26])
                OP_RTYPE: begin
                    wa = w[15:11];
                    case (w[5:0])
                        FN_ADDU: val = a + b;
                        FN_SUBU: val = a - b;
                        FN_AND:  val = a & b;
                        FN_OR:   val = a | b;
                        FN_XOR:  val = a ^ b;
                        FN_SLT:  val = ($signed(a) < $signed(b)) ? 1 : 0;
                        FN_SLTU: val = (a < b) ? 1 : 0;
                        FN_SLL:  val = b << w[10:6];
                        FN_SRL:  val = b >> w[10:6];
                        FN_SRA:  val = $signed(b) >>> w[10:6];
                        FN_SLLV: val = b << a[4:0];
                        FN_SRLV: val = b >> a[4:0];
                        FN_SRAV: val = $signed(b) >>> a[4:0];
                        FN_JR: begin
                            wr = 0;
                            take = 1;
                            ntgt = a;
                        end
                        default: wr = 0;
                    endcase
                end
                OP_ADDIU: val = a + se;
                OP_SLTI:  val = ($signed(a) < $signed(se)) ? 1 : 0;
                OP_SLTIU: val = (a < se) ? 1 : 0;
                OP_ANDI:  val = a & ze;
                OP_ORI:   val = a | ze;
                OP_XORI:  val = a ^ ze;
                OP_LUI:   val = {w[15:0], 16'h0000};
                OP_LW: begin
                    add_txn(0, ea, '0, 4'hf);
                    val = model_mem.exists(ea) ? model_mem[ea] : '0;
                end
                OP_SW: begin
                    wr = 0;
                    add_txn(1, {ea[31:2], 2'b00}, b, (ea[1:0] != 0) ? 4'h0 : 4'hf);
                    if (ea[1:0] == 0) model_mem[ea] = b;
                end
                OP_BEQ: begin
                    wr = 0;
                    take = (a == b);
                end
                OP_BNE: begin
                    wr = 0;
                    take = (a != b);
                end
                OP_J: begin
                    wr = 0;
                    take = 1;
                    ntgt = {pc[31:28], w[25:0], 2'b00};
                end
                default: wr = 0;
            endcase
            if (wr && wa != 0) model_regs[wa] = val;
            npc = pend ? tgt : pc + 4;
            pend = take;
            if (take) tgt = ntgt;
            pc = npc;
        end
    endtask

    task automatic check_txn();
        assert (txn_idx < exp_write.size())
            else stop_run("the core made a bus access past the program end");
        assert (write == exp_write[txn_idx])
            else stop_run("the core made a read where a write was expected, or the reverse");
        assert (address == exp_addr[txn_idx])
            else report_mismatch("bus address", exp_addr[txn_idx], address);
        assert (byteenable == exp_be[txn_idx])
            else report_mismatch("byteenable", exp_be[txn_idx], byteenable);
        if (write) begin
            assert (writedata == exp_data[txn_idx])
                else report_mismatch("write data", exp_data[txn_idx], writedata);
        end
        txn_idx++;
    endtask

    // Avalon slave with random wait states that samples at the edge and drives just after it
    always @(posedge clk) begin : bus_model
        bit          acc;
        logic [31:0] next_rd;
        acc = !reset && (read || write) && !waitrequest;
        next_rd = readdata;
        if (!reset) assert (active === 1'b1 || halt_seen)
            else stop_run("active fell before the core fetched from the halt address");
        if (!reset && read && address == `MIPS_HALT_ADDR) begin
            halt_seen = 1;
        end else if (acc) begin
            check_txn();
            if (write) begin
                for (int k = 0; k < 4; k++) begin
                    if (byteenable[k]) bus_mem[address][8 * k +: 8] = writedata[8 * k +: 8];
                end
            end else begin
                next_rd = bus_mem.exists(address) ? bus_mem[address] : '0;
            end
        end
        #1;
        readdata = next_rd;
        if (wait_run >= 3 || $urandom_range(99, 0) >= 30) begin   // never more than three in a row
            waitrequest = 1'b0;
            wait_run = 0;
        end else begin
            waitrequest = 1'b1;
            wait_run++;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        stop_run("watchdog timeout, the core did not halt in time");
    end

    initial begin
        reset = 1'b1;
        waitrequest = 1'b0;
        readdata = '0;
        void'($urandom(32'hb1d7));
        build_program();
        run_model();
        bus_mem = init_mem;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (txn_idx < 8);
        reset = 1'b1;                                     // restart in the middle of the program
        bus_mem = init_mem;
        txn_idx = 0;
        halt_seen = 0;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        #1 assert (read && address == RV && active)
            else stop_run("after a reset in mid-run the core did not fetch from the reset vector");
        do begin
            @(posedge clk);
            #1;
        end while (active !== 1'b0);
        assert (txn_idx == exp_write.size())
            else report_mismatch("bus access count", exp_write.size(), txn_idx);
        repeat (20) begin
            @(posedge clk);
            #1 assert (!read && !write && !active)
                else stop_run("the core made a bus request after it halted");
        end
        assert (register_v0 == model_regs[`MIPS_REG_V0])
            else report_mismatch("register_v0", model_regs[`MIPS_REG_V0], register_v0);
        foreach (model_mem[a]) begin
            assert (bus_mem[a] == model_mem[a]) else report_mismatch("data memory", model_mem[a],
                                                                     bus_mem[a]);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
